/* Bender.yml */
package:
  name: lcd_message

sources:
  - logic/lcd_msg_pkg.sv
  - logic/lcd_field_formatter.sv
  - logic/lcd_message_composer.sv
  - logic/lcd_frame_register.sv
  - logic/lcd_message_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_lcd_message.sv

/* filelist.f */
+incdir+testbench
logic/lcd_msg_pkg.sv
logic/lcd_field_formatter.sv
logic/lcd_message_composer.sv
logic/lcd_frame_register.sv
logic/lcd_message_top.sv
testbench/tb_lcd_message.sv

/* logic/lcd_field_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_field_formatter #(
    parameter int PROGRESS_FULL = 100
) (
    input  logic                   [7:0] brew_progress,
    input  logic                   [7:0] service_days,
    input  logic                   [7:0] service_hours,
    output lcd_msg_pkg::lcd_line_t       bar_line,
    output lcd_msg_pkg::lcd_line_t       service_line
);
    import lcd_msg_pkg::*;

    // ========================================
    // Progress bar
    // ========================================

    logic [11:0] scaled_progress;
    logic [4:0]  filled_count;

    // progress * 16 / full, clamped to the line width
    assign scaled_progress = 12'({brew_progress, 4'b0000} / PROGRESS_FULL);
    assign filled_count    = (scaled_progress > 12'(LCD_COLS)) ? 5'(LCD_COLS)
                                                               : scaled_progress[4:0];

    always_comb begin
        for (int i = 0; i < LCD_COLS; i++) begin
            // '#' for the filled part, '-' for the rest
            bar_line[(LCD_COLS-1-i)*8 +: 8] = (i < filled_count) ? 8'h23 : 8'h2D;
        end
    end

    always_comb begin
        assert (filled_count <= 5'(LCD_COLS))
            else $error("progress bar fill count %0d beyond line width", filled_count);
    end

    // ========================================
    // Service time
    // ========================================

    logic [7:0] days_tens;
    logic [7:0] days_ones;
    logic [7:0] hours_tens;
    logic [7:0] hours_ones;

    assign days_tens  = digit_char(4'(service_days / 8'd10));
    assign days_ones  = digit_char(4'(service_days % 8'd10));
    assign hours_tens = digit_char(4'((service_hours / 8'd10) % 8'd10));
    assign hours_ones = digit_char(4'(service_hours % 8'd10));

    always_comb begin
        if (service_days > 8'd99) begin
            service_line = lcd_text("99+ days");
        end else if (service_days != 8'd0) begin
            // "DDd HHh"
            service_line = {days_tens, days_ones, 8'h64, 8'h20,
                            hours_tens, hours_ones, 8'h68, {9{8'h20}}};
        end else begin
            // Less than a day, hours only
            service_line = {hours_tens, hours_ones, 8'h68, {13{8'h20}}};
        end
    end

endmodule

`default_nettype wire

/* logic/lcd_frame_register.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_frame_register (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lcd_msg_pkg::lcd_frame_t next_frame,
    output lcd_msg_pkg::lcd_frame_t frame,
    output logic                    message_updated
);
    import lcd_msg_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Blank display out of reset
            frame.line1     <= LCD_BLANK_LINE;
            frame.line2     <= LCD_BLANK_LINE;
            message_updated <= 1'b0;
        end else begin
            frame           <= next_frame;
            message_updated <= (next_frame != frame);
        end
    end

    // ========================================
    // Strobe tracks real text changes
    // ========================================

    a_update_on_change: assert property (
        @(posedge clk) disable iff (!rst_n)
        message_updated |-> (frame != $past(frame))
    ) else $error("update strobe without a frame change");

    a_no_silent_change: assert property (
        @(posedge clk) disable iff (!rst_n)
        !message_updated |-> (frame == $past(frame))
    ) else $error("frame changed with no update strobe");

endmodule

`default_nettype wire

/* logic/lcd_message_composer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_message_composer #(
    parameter int PROGRESS_FULL = 100
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lcd_msg_pkg::menu_sel_t       sel,
    input  lcd_msg_pkg::machine_status_t status,
    input  logic                   [7:0] service_hours,
    output lcd_msg_pkg::lcd_frame_t      next_frame
);
    import lcd_msg_pkg::*;

    lcd_line_t bar_line;
    lcd_line_t service_line;
    logic      any_issue;

    lcd_field_formatter #(
        .PROGRESS_FULL(PROGRESS_FULL)
    ) i_formatter (
        .brew_progress(status.brew_progress),
        .service_days (status.service_days),
        .service_hours(service_hours),
        .bar_line     (bar_line),
        .service_line (service_line)
    );

    assign any_issue = status.error_present || (status.warning_count != 4'd0);

    // ========================================
    // Screen selection
    // ========================================

    always_comb begin
        next_frame.line1 = LCD_BLANK_LINE;
        next_frame.line2 = LCD_BLANK_LINE;

        case (sel.state)
            MENU_SPLASH: begin
                next_frame.line1 = lcd_text("Coffee Machine");
                if (any_issue) begin
                    next_frame.line2 = lcd_text("W:w E:e Press->");
                    // Count digits go in columns 2 and 6
                    next_frame.line2[111:104] = digit_char(status.warning_count);
                    next_frame.line2[79:72]   = digit_char(status.error_count);
                end else begin
                    next_frame.line2 = lcd_text("Press Start");
                end
            end

            MENU_COFFEE_SELECT: begin
                next_frame.line1 = sel.coffee_bin ? lcd_text("Coffee Bin: [2]")
                                                  : lcd_text("Coffee Bin: [1]");
                next_frame.line2 = lcd_text("<-> Select");
            end

            MENU_DRINK_SELECT: begin
                case (sel.drink)
                    DRINK_BLACK:         next_frame.line1 = lcd_text("Drink: [Black]");
                    DRINK_CREAM:         next_frame.line1 = lcd_text("Drink: [Cream]");
                    DRINK_LATTE:         next_frame.line1 = lcd_text("Drink: [Latte]");
                    DRINK_MOCHA:         next_frame.line1 = lcd_text("Drink: [Mocha]");
                    DRINK_HOT_CHOCOLATE: next_frame.line1 = lcd_text("Drink:[HotChoco]");
                    default:             next_frame.line1 = lcd_text("Drink: ?");
                endcase
                next_frame.line2 = lcd_text("<-> Select");
            end

            MENU_SIZE_SELECT: begin
                case (sel.size)
                    SIZE_8OZ:  next_frame.line1 = lcd_text("Size: [8oz]");
                    SIZE_12OZ: next_frame.line1 = lcd_text("Size: [12oz]");
                    SIZE_16OZ: next_frame.line1 = lcd_text("Size: [16oz]");
                    default:   next_frame.line1 = lcd_text("Size: ?");
                endcase
                next_frame.line2 = lcd_text("<-> Select");
            end

            MENU_CONFIRM: begin
                // Unlisted drink or size leaves line 1 blank
                case ({sel.drink, sel.size})
                    {DRINK_BLACK, SIZE_8OZ}:          next_frame.line1 = lcd_text("Black Coffee 8z");
                    {DRINK_BLACK, SIZE_12OZ}:         next_frame.line1 = lcd_text("Black Coffee12z");
                    {DRINK_BLACK, SIZE_16OZ}:         next_frame.line1 = lcd_text("Black Coffee16z");
                    {DRINK_CREAM, SIZE_8OZ}:          next_frame.line1 = lcd_text("Coffee+Cream 8z");
                    {DRINK_CREAM, SIZE_12OZ}:         next_frame.line1 = lcd_text("Coffee+Cream12z");
                    {DRINK_CREAM, SIZE_16OZ}:         next_frame.line1 = lcd_text("Coffee+Cream16z");
                    {DRINK_LATTE, SIZE_8OZ}:          next_frame.line1 = lcd_text("Latte 8oz");
                    {DRINK_LATTE, SIZE_12OZ}:         next_frame.line1 = lcd_text("Latte 12oz");
                    {DRINK_LATTE, SIZE_16OZ}:         next_frame.line1 = lcd_text("Latte 16oz");
                    {DRINK_MOCHA, SIZE_8OZ}:          next_frame.line1 = lcd_text("Mocha 8oz");
                    {DRINK_MOCHA, SIZE_12OZ}:         next_frame.line1 = lcd_text("Mocha 12oz");
                    {DRINK_MOCHA, SIZE_16OZ}:         next_frame.line1 = lcd_text("Mocha 16oz");
                    {DRINK_HOT_CHOCOLATE, SIZE_8OZ}:  next_frame.line1 = lcd_text("Hot Choco 8oz");
                    {DRINK_HOT_CHOCOLATE, SIZE_12OZ}: next_frame.line1 = lcd_text("Hot Choco 12oz");
                    {DRINK_HOT_CHOCOLATE, SIZE_16OZ}: next_frame.line1 = lcd_text("Hot Choco 16oz");
                    default:                          next_frame.line1 = LCD_BLANK_LINE;
                endcase
                next_frame.line2 = lcd_text("Start? Cancel?");
            end

            MENU_BREWING: begin
                if (!status.temp_ready) begin
                    next_frame.line1 = lcd_text("Heating Water...");
                    next_frame.line2 = lcd_text("Please Wait");
                end else begin
                    next_frame.line1 = lcd_text("Brewing...");
                    next_frame.line2 = bar_line;
                end
            end

            MENU_COMPLETE: begin
                next_frame.line1 = lcd_text("Enjoy Your");
                next_frame.line2 = lcd_text("Beverage!");
            end

            MENU_ABORT_CONFIRM: begin
                next_frame.line1 = lcd_text("Abort Brewing?");
                next_frame.line2 = lcd_text("Start=Yes Can=No");
            end

            MENU_MAINT_OPTIONS: begin
                next_frame.line1 = lcd_text("Maintenance Menu");
                case (sel.maint_opt)
                    MAINT_VIEW_ERRORS:  next_frame.line2 = lcd_text("[View Errors]<->");
                    MAINT_MANUAL_CHECK: next_frame.line2 = lcd_text("[Manual Check]<>");
                    MAINT_SERVICE_TIME: next_frame.line2 = lcd_text("[Service Time]<>");
                    default:            next_frame.line2 = lcd_text("[Exit]<->");
                endcase
            end

            MENU_MAINT_VIEW: begin
                // Same state serves both the issue summary and the service timer
                if (sel.maint_opt == MAINT_SERVICE_TIME) begin
                    next_frame.line1 = lcd_text("Time Since Srvc");
                    next_frame.line2 = service_line;
                end else if (status.error_present) begin
                    next_frame.line1 = lcd_text("Active Issues:");
                    next_frame.line2 = lcd_text("See Error Cycle");
                end else if (any_issue) begin
                    next_frame.line1 = lcd_text("Active Issues:");
                    next_frame.line2 = lcd_text("See Warnings");
                end else begin
                    next_frame.line1 = lcd_text("No Active");
                    next_frame.line2 = lcd_text("Errors/Warnings");
                end
            end

            default: begin
                next_frame.line1 = lcd_text("System Error");
                next_frame.line2 = lcd_text("Unknown State");
            end
        endcase
    end

    // Known inputs must always give a fully known frame
    a_frame_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(next_frame)
    ) else $error("composed frame has unknown bits");

endmodule

`default_nettype wire

/* logic/lcd_message_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lcd_message_top #(
    // Progress value that fills the whole bar
    parameter int PROGRESS_FULL = 100
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lcd_msg_pkg::menu_sel_t       sel,
    input  lcd_msg_pkg::machine_status_t status,
    input  logic                   [7:0] service_hours,
    output lcd_msg_pkg::lcd_frame_t      frame,
    output logic                         message_updated
);
    import lcd_msg_pkg::*;

    lcd_frame_t next_frame;

    // Combinational text for the current screen
    lcd_message_composer #(
        .PROGRESS_FULL(PROGRESS_FULL)
    ) i_composer (
        .clk          (clk),
        .rst_n        (rst_n),
        .sel          (sel),
        .status       (status),
        .service_hours(service_hours),
        .next_frame   (next_frame)
    );

    // One cycle to the display, plus change strobe
    lcd_frame_register i_frame_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .next_frame     (next_frame),
        .frame          (frame),
        .message_updated(message_updated)
    );

endmodule

`default_nettype wire

/* logic/lcd_msg_pkg.sv */
`default_nettype none

package lcd_msg_pkg;

    localparam int LCD_COLS = 16;

    typedef logic [LCD_COLS*8-1:0] lcd_line_t;

    // Leftmost character sits in the top byte
    localparam lcd_line_t LCD_BLANK_LINE = {LCD_COLS{8'h20}};

    typedef struct packed {
        lcd_line_t line1;
        lcd_line_t line2;
    } lcd_frame_t;

    // Menu FSM encodings, only the screens shown here are named
    typedef enum logic [3:0] {
        MENU_SPLASH        = 4'd0,
        MENU_COFFEE_SELECT = 4'd2,
        MENU_DRINK_SELECT  = 4'd3,
        MENU_SIZE_SELECT   = 4'd4,
        MENU_CONFIRM       = 4'd5,
        MENU_BREWING       = 4'd6,
        MENU_COMPLETE      = 4'd7,
        MENU_ABORT_CONFIRM = 4'd11,
        MENU_MAINT_OPTIONS = 4'd13,
        MENU_MAINT_VIEW    = 4'd14
    } menu_state_e;

    typedef enum logic [2:0] {
        DRINK_BLACK         = 3'd0,
        DRINK_CREAM         = 3'd1,
        DRINK_LATTE         = 3'd2,
        DRINK_MOCHA         = 3'd3,
        DRINK_HOT_CHOCOLATE = 3'd4
    } drink_e;

    typedef enum logic [1:0] {
        SIZE_8OZ  = 2'd0,
        SIZE_12OZ = 2'd1,
        SIZE_16OZ = 2'd2
    } size_e;

    typedef enum logic [1:0] {
        MAINT_VIEW_ERRORS  = 2'd0,
        MAINT_MANUAL_CHECK = 2'd1,
        MAINT_SERVICE_TIME = 2'd2,
        MAINT_EXIT         = 2'd3
    } maint_opt_e;

    typedef struct packed {
        menu_state_e state;
        logic        coffee_bin;
        drink_e      drink;
        size_e       size;
        maint_opt_e  maint_opt;
    } menu_sel_t;

    typedef struct packed {
        logic [7:0] brew_progress;
        logic [3:0] warning_count;
        logic [3:0] error_count;
        logic       error_present;
        logic       temp_ready;
        logic [7:0] service_days;   // saturates at 255 upstream
    } machine_status_t;

    // ========================================
    // Text helpers
    // ========================================

    // Literal to line, padded with spaces, cut at LCD_COLS
    function automatic lcd_line_t lcd_text(input string s);
        lcd_line_t line;
        line = LCD_BLANK_LINE;
        for (int i = 0; i < LCD_COLS; i++) begin
            if (i < s.len()) begin
                line[(LCD_COLS-1-i)*8 +: 8] = s[i];
            end
        end
        return line;
    endfunction

    // Single decimal digit, blank when out of range
    function automatic logic [7:0] digit_char(input logic [3:0] value);
        if (value <= 4'd9) begin
            return 8'h30 + {4'h0, value};
        end
        return 8'h20;
    endfunction

endpackage

`default_nettype wire

/* testbench/tb_lcd_message_tests.svh */
`ifndef TB_LCD_MESSAGE_TESTS_SVH
`define TB_LCD_MESSAGE_TESTS_SVH

// ========================================
// Reference text model
// ========================================

function automatic string count_digit(input logic [3:0] n);
    if (n <= 4'd9) begin
        return $sformatf("%0d", n);
    end
    return " ";
endfunction

function automatic string drink_select_text(input int d);
    case (d)
        0:       return "Drink: [Black]";
        1:       return "Drink: [Cream]";
        2:       return "Drink: [Latte]";
        3:       return "Drink: [Mocha]";
        4:       return "Drink:[HotChoco]";
        default: return "Drink: ?";
    endcase
endfunction

// Drink and size names as the confirm screen spells them
function automatic string confirm_name(input int d, input int z);
    case (d * 3 + z)
        0:       return "Black Coffee 8z";
        1:       return "Black Coffee12z";
        2:       return "Black Coffee16z";
        3:       return "Coffee+Cream 8z";
        4:       return "Coffee+Cream12z";
        5:       return "Coffee+Cream16z";
        6:       return "Latte 8oz";
        7:       return "Latte 12oz";
        8:       return "Latte 16oz";
        9:       return "Mocha 8oz";
        10:      return "Mocha 12oz";
        11:      return "Mocha 16oz";
        12:      return "Hot Choco 8oz";
        13:      return "Hot Choco 12oz";
        14:      return "Hot Choco 16oz";
        default: return "";
    endcase
endfunction

function automatic string maint_option_text(input int opt);
    case (opt)
        0:       return "[View Errors]<->";
        1:       return "[Manual Check]<>";
        2:       return "[Service Time]<>";
        default: return "[Exit]<->";
    endcase
endfunction

function automatic string bar_text(input int progress);
    int    filled;
    string line;
    filled = progress * LCD_COLS / PROGRESS_FULL;
    if (filled > LCD_COLS) begin
        filled = LCD_COLS;
    end
    line = "";
    for (int i = 0; i < LCD_COLS; i++) begin
        if (i < filled) begin
            line = {line, "#"};
        end else begin
            line = {line, "-"};
        end
    end
    return line;
endfunction

function automatic string service_text(input int days, input int hours);
    if (days > 99) begin
        return "99+ days";
    end else if (days != 0) begin
        return $sformatf("%02dd %02dh", days, hours % 100);
    end
    return $sformatf("%02dh", hours % 100);
endfunction

function automatic lcd_frame_t expected_frame(input menu_sel_t s, input machine_status_t st,
                                              input logic [7:0] hours);
    lcd_frame_t f;
    string      l1;
    string      l2;
    l1 = "";
    l2 = "";
    case (s.state)
        MENU_SPLASH: begin
            l1 = "Coffee Machine";
            if (st.error_present || st.warning_count > 0) begin
                l2 = $sformatf("W:%s E:%s Press->", count_digit(st.warning_count),
                               count_digit(st.error_count));
            end else begin
                l2 = "Press Start";
            end
        end
        MENU_COFFEE_SELECT: begin
            l1 = $sformatf("Coffee Bin: [%0d]", s.coffee_bin + 1);
            l2 = "<-> Select";
        end
        MENU_DRINK_SELECT: begin
            l1 = drink_select_text(int'(s.drink));
            l2 = "<-> Select";
        end
        MENU_SIZE_SELECT: begin
            if (s.size <= 2'd2) begin
                l1 = $sformatf("Size: [%0doz]", 8 + 4 * s.size);
            end else begin
                l1 = "Size: ?";
            end
            l2 = "<-> Select";
        end
        MENU_CONFIRM: begin
            if (s.drink <= 3'd4 && s.size <= 2'd2) begin
                l1 = confirm_name(int'(s.drink), int'(s.size));
            end
            l2 = "Start? Cancel?";
        end
        MENU_BREWING: begin
            if (!st.temp_ready) begin
                l1 = "Heating Water...";
                l2 = "Please Wait";
            end else begin
                l1 = "Brewing...";
                l2 = bar_text(int'(st.brew_progress));
            end
        end
        MENU_COMPLETE: begin
            l1 = "Enjoy Your";
            l2 = "Beverage!";
        end
        MENU_ABORT_CONFIRM: begin
            l1 = "Abort Brewing?";
            l2 = "Start=Yes Can=No";
        end
        MENU_MAINT_OPTIONS: begin
            l1 = "Maintenance Menu";
            l2 = maint_option_text(int'(s.maint_opt));
        end
        MENU_MAINT_VIEW: begin
            if (s.maint_opt == MAINT_SERVICE_TIME) begin
                l1 = "Time Since Srvc";
                l2 = service_text(int'(st.service_days), int'(hours));
            end else if (st.error_present) begin
                l1 = "Active Issues:";
                l2 = "See Error Cycle";
            end else if (st.warning_count > 0) begin
                l1 = "Active Issues:";
                l2 = "See Warnings";
            end else begin
                l1 = "No Active";
                l2 = "Errors/Warnings";
            end
        end
        default: begin
            l1 = "System Error";
            l2 = "Unknown State";
        end
    endcase
    f.line1 = lcd_text(l1);
    f.line2 = lcd_text(l2);
    return f;
endfunction

// ========================================
// Stimulus helpers
// ========================================

// Drive at one edge and sample at the falling edge after the capture edge
task automatic apply_inputs(input menu_sel_t s, input machine_status_t st,
                            input logic [7:0] hours);
    @(posedge clk);
    sel           <= s;
    status        <= st;
    service_hours <= hours;
    @(posedge clk);
    @(negedge clk);
endtask

task automatic show_and_check(input string label, input menu_sel_t s,
                              input machine_status_t st, input logic [7:0] hours);
    apply_inputs(s, st, hours);
    check_value({"frame ", label}, frame, expected_frame(s, st, hours));
endtask

// ========================================
// Directed tests
// ========================================

task automatic reset_values();
    lcd_frame_t blank;
    int         errs;
    errs        = error_count;
    blank.line1 = lcd_text("");
    blank.line2 = lcd_text("");
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("frame in reset", frame, blank);
    check_value("message_updated in reset", message_updated, 1'b0);
    repeat (3) @(posedge clk);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("frame after reset", frame, blank);
    check_value("message_updated after reset", message_updated, 1'b0);
    // First composed frame differs from blank, so the strobe fires
    @(posedge clk);
    @(negedge clk);
    check_value("first frame", frame, expected_frame(sel, status, service_hours));
    check_value("first message_updated", message_updated, 1'b1);
    report_test("reset", errs);
endtask

task automatic splash_screen();
    menu_sel_t       s;
    machine_status_t st;
    int              errs;
    errs = error_count;
    s    = '0;
    st   = '0;
    show_and_check("splash idle", s, st, 8'd0);
    st.warning_count = 4'd3;
    st.error_count   = 4'd2;
    show_and_check("splash counts", s, st, 8'd0);
    // Two-digit count shows as a blank
    st.warning_count = 4'd12;
    show_and_check("splash wide count", s, st, 8'd0);
    report_test("splash", errs);
endtask

task automatic selection_screens();
    menu_sel_t       s;
    machine_status_t st;
    int              errs;
    errs    = error_count;
    s       = '0;
    st      = '0;
    s.state = MENU_COFFEE_SELECT;
    for (int b = 0; b < 2; b++) begin
        s.coffee_bin = b[0];
        show_and_check($sformatf("coffee bin %0d", b + 1), s, st, 8'd0);
    end
    s.state = MENU_DRINK_SELECT;
    for (int d = 0; d < 5; d++) begin
        s.drink = drink_e'(d);
        show_and_check($sformatf("drink %0d", d), s, st, 8'd0);
    end
    s.state = MENU_SIZE_SELECT;
    for (int z = 0; z < 3; z++) begin
        s.size = size_e'(z);
        show_and_check($sformatf("size %0d", z), s, st, 8'd0);
    end
    s.state = MENU_CONFIRM;
    for (int d = 0; d < 5; d++) begin
        for (int z = 0; z < 3; z++) begin
            s.drink = drink_e'(d);
            s.size  = size_e'(z);
            show_and_check($sformatf("confirm %0d/%0d", d, z), s, st, 8'd0);
        end
    end
    report_test("selection", errs);
endtask

task automatic brewing_screen();
    menu_sel_t       s;
    machine_status_t st;
    int              errs;
    errs             = error_count;
    s                = '0;
    st               = '0;
    s.state          = MENU_BREWING;
    st.brew_progress = 8'd50;
    show_and_check("heating", s, st, 8'd0);
    st.temp_ready    = 1'b1;
    st.brew_progress = 8'd0;
    show_and_check("bar 0", s, st, 8'd0);
    st.brew_progress = 8'd50;
    show_and_check("bar 50", s, st, 8'd0);
    st.brew_progress = 8'd100;
    show_and_check("bar 100", s, st, 8'd0);
    // Beyond full scale the bar clamps
    st.brew_progress = 8'd200;
    show_and_check("bar 200", s, st, 8'd0);
    for (int i = 0; i < 10; i++) begin
        st.brew_progress = 8'($random(seed));
        show_and_check($sformatf("bar %0d", st.brew_progress), s, st, 8'd0);
    end
    report_test("brewing", errs);
endtask

task automatic maintenance_screens();
    menu_sel_t       s;
    machine_status_t st;
    logic [7:0]      hours;
    int              errs;
    errs    = error_count;
    s       = '0;
    st      = '0;
    s.state = MENU_MAINT_OPTIONS;
    for (int opt = 0; opt < 4; opt++) begin
        s.maint_opt = maint_opt_e'(opt);
        show_and_check($sformatf("option %0d", opt), s, st, 8'd0);
    end
    s.state          = MENU_MAINT_VIEW;
    s.maint_opt      = MAINT_VIEW_ERRORS;
    st.error_present = 1'b1;
    show_and_check("view errors", s, st, 8'd0);
    st.error_present = 1'b0;
    st.warning_count = 4'd4;
    show_and_check("view warnings", s, st, 8'd0);
    st.warning_count = 4'd0;
    show_and_check("view clear", s, st, 8'd0);

    s.maint_opt     = MAINT_SERVICE_TIME;
    st.service_days = 8'd0;
    show_and_check("service hours", s, st, 8'd17);
    st.service_days = 8'd5;
    show_and_check("service 5d 7h", s, st, 8'd7);
    st.service_days = 8'd150;
    show_and_check("service 150d", s, st, 8'd3);
    for (int i = 0; i < 3; i++) begin
        st.service_days = 8'($unsigned($random(seed)) % 100);
        hours           = 8'($random(seed));
        show_and_check($sformatf("service %0d/%0d", st.service_days, hours), s, st, hours);
    end

    st      = '0;
    s.state = MENU_ABORT_CONFIRM;
    show_and_check("abort confirm", s, st, 8'd0);
    s.state = MENU_COMPLETE;
    show_and_check("complete", s, st, 8'd0);
    s.state = menu_state_e'(4'd9);
    show_and_check("dropped state", s, st, 8'd0);
    report_test("maintenance", errs);
endtask

task automatic update_strobe();
    menu_sel_t       s;
    machine_status_t st;
    lcd_frame_t      old_frame;
    int              errs;
    errs = error_count;
    s    = '0;
    st   = '0;
    apply_inputs(s, st, 8'd0);
    @(negedge clk);
    check_value("message_updated held", message_updated, 1'b0);
    // Option change that leaves the splash text alone
    s.maint_opt = MAINT_EXIT;
    @(posedge clk);
    sel <= s;
    @(posedge clk);
    @(negedge clk);
    check_value("message_updated same text", message_updated, 1'b0);
    check_value("frame same text", frame, expected_frame(s, st, 8'd0));
    old_frame = expected_frame(s, st, 8'd0);
    s.state   = MENU_COMPLETE;
    @(posedge clk);
    sel <= s;
    // New text waits for the capture edge
    @(negedge clk);
    check_value("frame before change", frame, old_frame);
    check_value("message_updated before change", message_updated, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_value("message_updated on change", message_updated, 1'b1);
    check_value("frame on change", frame, expected_frame(s, st, 8'd0));
    @(negedge clk);
    check_value("message_updated after change", message_updated, 1'b0);
    report_test("update strobe", errs);
endtask

`endif

/* testbench/tb_lcd_message.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_message;
    import lcd_msg_pkg::*;

    localparam int PROGRESS_FULL = 100;
    // Six tests run in about 150 cycles, so this leaves wide margin
    localparam int TIMEOUT_CYCLES = 400;

    logic            clk;
    logic            rst_n;
    menu_sel_t       sel;
    machine_status_t status;
    logic [7:0]      service_hours;
    lcd_frame_t      frame;
    logic            message_updated;

    int     check_count = 0;
    int     error_count = 0;
    int     tests_ok    = 0;
    int     tests_bad   = 0;
    int     cycle_count = 0;
    integer seed        = 35139;

    lcd_message_top #(
        .PROGRESS_FULL(PROGRESS_FULL)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .sel            (sel),
        .status         (status),
        .service_hours  (service_hours),
        .frame          (frame),
        .message_updated(message_updated)
    );

    // ========================================
    // Clock and run limit
    // ========================================

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // ========================================
    // Checking and reporting
    // ========================================

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %0h, expected %0h", name, got, expected);
        end
    endtask

    // One line per finished test
    task automatic report_test(input string name, input int errors_before);
        int new_errors;
        new_errors = error_count - errors_before;
        if (new_errors == 0) begin
            tests_ok++;
            $display("%-16s ok", name);
        end else begin
            tests_bad++;
            $display("%-16s %0d mismatches", name, new_errors);
        end
    endtask

    `include "tb_lcd_message_tests.svh"

    initial begin
        rst_n         = 1'b0;
        sel           = '0;
        status        = '0;
        service_hours = 8'd0;

        reset_values();
        splash_screen();
        selection_screens();
        brewing_screen();
        maintenance_screens();
        update_strobe();

        $display("Summary: %0d checks, %0d mismatches, %0d tests ok, %0d tests with errors",
                 check_count, error_count, tests_ok, tests_bad);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
